/* tb.f */
bus_pkg.sv
reg_map_pkg.sv
reg_addr_decode.sv
reg_slv_fsm.sv
reg_file.sv
ext_port_route.sv
reg_slv_top.sv
reg_slv_chk.sv
tb_reg_slv.sv

/* Makefile */
SRCS := $(shell cat tb.f)

run: obj_dir/Vtb_reg_slv
	out="$$(./obj_dir/Vtb_reg_slv +verilator+error+limit+100)"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

obj_dir/Vtb_reg_slv: $(SRCS) tb.f
	verilator --binary --timing --assert -f tb.f --top-module tb_reg_slv

clean:
	rm -rf obj_dir

.PHONY: run clean

/* tb_reg_slv.sv */
`timescale 1ns/100ps

module tb_reg_slv;

    localparam int N = 8;
    localparam int M = 2;
    localparam logic [15:0] SOFT_A  = 16'(reg_map_pkg::SOFT_RST_ADDR);
    localparam logic [15:0] EXT_A   = 16'(reg_map_pkg::EXT_BASE);
    localparam logic [15:0] EXT_END = 16'(reg_map_pkg::EXT_BASE + M * reg_map_pkg::EXT_SPAN);

    typedef struct packed {
        logic        wr;
        logic [15:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
    } txn_t;

    logic         clk, rstn, req_vld, rd_en, wr_en, req_rdy, ack_vld, ack_rdy;
    logic [15:0]  addr, ext_addr;
    logic [31:0]  wr_data, rd_data, ext_wr_data;
    logic [M-1:0] ext_req_vld, ext_req_rdy, ext_ack_vld;
    logic         ext_rd_en, ext_wr_en;
    logic [31:0]  ext_word [M];
    logic [31:0]  ext_mem [M][64];
    logic [31:0]  ref_mem [M][64];
    logic [31:0]  ref_regs [N];
    logic [31:0]  lfsr_q = 32'd84705;
    txn_t         tbl [$];
    // direction of the transaction in flight, for the external slaves
    logic         cur_wr;

    // port k read data sits at bits k*32 and up
    wire [M*32-1:0] ext_rd_data = {ext_word[1], ext_word[0]};

    reg_slv_top #(.N(N), .M(M)) uut (.*);

    bind reg_slv_fsm reg_slv_chk #(.DATA_WIDTH(DATA_WIDTH)) u_chk (
        .clk(clk), .rstn(rstn), .state(state), .req_rdy(req_rdy), .ack_vld(ack_vld),
        .ack_rdy(ack_rdy), .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // reference model, works out the expected read data as the table is built
    task automatic add_txn(input logic wr, input logic [15:0] a, input logic [31:0] d);
        logic [31:0] exp;
        exp = 32'h0;
        if (a == SOFT_A) begin
            if (wr) begin
                foreach (ref_regs[i]) ref_regs[i] = reg_map_pkg::REG_RESET;
            end else begin
                exp = bus_pkg::DUMMY_DATA;
            end
        end else if (a < 16'(N * 4) && a[1:0] == 2'b00) begin
            if (wr) ref_regs[a[4:2]] = d;
            else exp = ref_regs[a[4:2]];
        end else if (a >= EXT_A && a < EXT_END) begin
            // 256 byte windows, so bit 8 picks the port
            if (wr) ref_mem[a[8]][a[7:2]] = d;
            else exp = ref_mem[a[8]][a[7:2]];
        end else if (!wr) begin
            exp = bus_pkg::DUMMY_DATA;
        end
        tbl.push_back('{wr, a, d, exp});
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [15:0] ea [6];
        for (int i = 0; i < N; i++) add_txn(1'b1, 16'(i * 4), take_bits(32));
        // misaligned and unmapped writes must land nowhere
        add_txn(1'b1, 16'h0006, 32'h5a5a_0006);
        add_txn(1'b1, 16'h0800, 32'h5a5a_0800);
        for (int i = 0; i < N; i++) add_txn(1'b0, 16'(i * 4), '0);
        add_txn(1'b0, 16'h0800, '0);
        add_txn(1'b0, 16'h0006, '0);
        add_txn(1'b0, SOFT_A, '0);
        // ports alternate, random word in each window
        for (int i = 0; i < 6; i++) begin
            r = take_bits(6);
            ea[i] = EXT_A + {7'b0, i[0], r[5:0], 2'b00};
            add_txn(1'b1, ea[i], take_bits(32));
        end
        for (int i = 0; i < 6; i++) add_txn(1'b0, ea[i], '0);
        add_txn(1'b1, SOFT_A, 32'hffff_ffff);
        for (int i = 0; i < N; i++) add_txn(1'b0, 16'(i * 4), '0);
        for (int i = 0; i < 6; i++) add_txn(1'b0, ea[i], '0);
    endtask

    // external slave with random ready and ack delays
    task automatic ext_slave(input logic k);
        logic [31:0] rdat;
        forever begin
            @(negedge clk);
            if (ext_req_vld[k]) begin
                repeat (take_bits(2)) @(negedge clk);
                check_val("ext_req_vld", 32'(ext_req_vld), 32'(2'b01 << k));
                check_val("ext_rd_en", 32'(ext_rd_en), 32'(!cur_wr));
                check_val("ext_wr_en", 32'(ext_wr_en), 32'(cur_wr));
                ext_req_rdy[k] = 1'b1;
                if (ext_wr_en) ext_mem[k][ext_addr[7:2]] = ext_wr_data;
                rdat = ext_wr_en ? 32'h0 : ext_mem[k][ext_addr[7:2]];
                @(negedge clk);
                ext_req_rdy[k] = 1'b0;
                repeat (take_bits(2)) @(negedge clk);
                ext_ack_vld[k] = 1'b1;
                ext_word[k] = rdat;
                @(negedge clk);
                ext_ack_vld[k] = 1'b0;
                ext_word[k] = '0;
            end
        end
    endtask

    task automatic run_txn(input txn_t t);
        int lat;
        lat = 0;
        while (!req_rdy) @(negedge clk);
        cur_wr  = t.wr;
        req_vld = 1'b1;
        rd_en   = ~t.wr;
        wr_en   = t.wr;
        addr    = t.addr;
        wr_data = t.data;
        @(negedge clk);
        req_vld = 1'b0;
        rd_en   = 1'b0;
        wr_en   = 1'b0;
        check_val("req_rdy", 32'(req_rdy), 32'd0);
        while (!ack_vld) begin
            ack_rdy = take_bits(2) == 32'd0;
            @(negedge clk);
            lat++;
        end
        // internal, dummy and soft reset targets take exactly two cycles
        if (t.addr < EXT_A || t.addr >= EXT_END) begin
            check_val("ack latency", 32'(lat), 32'd2);
        end
        do begin
            if (!t.wr) check_val("rd_data", rd_data, t.exp);
            ack_rdy = take_bits(2) != 32'd0;
            @(negedge clk);
        end while (!ack_rdy);
        ack_rdy = 1'b0;
        check_val("ack_vld", 32'(ack_vld), 32'd0);
    endtask

    initial begin
        fork
            ext_slave(1'b0);
            ext_slave(1'b1);
        join
    end

    initial begin
        @(posedge rstn);
        repeat (tbl.size() * 64) @(posedge clk);
        $display("timeout: the transaction table did not finish in time");
        $display("Test failures found");
        $fatal(1);
    end

    initial begin
        rstn        = 1'b0;
        req_vld     = 1'b0;
        rd_en       = 1'b0;
        wr_en       = 1'b0;
        addr        = '0;
        wr_data     = '0;
        ack_rdy     = 1'b0;
        ext_req_rdy = '0;
        ext_ack_vld = '0;
        ext_word    = '{default: '0};
        cur_wr      = 1'b0;
        foreach (ref_regs[i]) ref_regs[i] = reg_map_pkg::REG_RESET;
        foreach (ext_mem[k, i]) begin
            ext_mem[k][i] = 32'hc0de_0000 + 32'(k * 256 + i);
            ref_mem[k][i] = ext_mem[k][i];
        end
        build_table();
        repeat (8) @(negedge clk);
        check_val("req_rdy", 32'(req_rdy), 32'd0);
        rstn = 1'b1;
        @(negedge clk);
        // bus idle before the first request
        check_val("req_rdy", 32'(req_rdy), 32'd1);
        check_val("ack_vld", 32'(ack_vld), 32'd0);
        check_val("ext_req_vld", 32'(ext_req_vld), 32'd0);
        foreach (tbl[i]) begin
            run_txn(tbl[i]);
            check_val("assertion failures", 32'(uut.u_fsm.u_chk.fail_cnt), 32'd0);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

/* reg_slv_chk.sv */
`timescale 1ns/100ps

module reg_slv_chk #(
    parameter int DATA_WIDTH = bus_pkg::DATA_WIDTH
) (
    input logic                  clk,
    input logic                  rstn,
    input bus_pkg::slv_state_t   state,
    input logic                  req_rdy,
    input logic                  ack_vld,
    input logic                  ack_rdy,
    input logic [DATA_WIDTH-1:0] rd_data
);

    // number of failed assertions so far
    int fail_cnt = 0;

    // response frozen while the master stalls
    a_ack_hold: assert property (@(posedge clk) disable iff (!rstn)
        ack_vld && !ack_rdy |=> ack_vld && $stable(rd_data))
        else begin
            fail_cnt++;
            $error("ack_vld or rd_data changed while ack_rdy was low");
        end

    a_no_overlap: assert property (@(posedge clk) disable iff (!rstn)
        !(req_rdy && ack_vld))
        else begin
            fail_cnt++;
            $error("req_rdy and ack_vld high in the same cycle");
        end

    // 2'b11 is outside the state encoding
    a_state_legal: assert property (@(posedge clk) disable iff (!rstn)
        2'(state) != 2'b11)
        else begin
            fail_cnt++;
            $error("slave FSM reached the unused state encoding");
        end

endmodule

/* reg_slv_top.sv */
`timescale 1ns/100ps

module reg_slv_top #(
    parameter int ADDR_WIDTH = bus_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = bus_pkg::DATA_WIDTH,
    parameter int N          = reg_map_pkg::REG_NUM,
    parameter int M          = reg_map_pkg::EXT_NUM
) (
    input  logic                    clk,
    input  logic                    rstn,
    // bus side
    input  logic                    req_vld,
    input  logic                    rd_en,
    input  logic                    wr_en,
    input  logic [ADDR_WIDTH-1:0]   addr,
    input  logic [DATA_WIDTH-1:0]   wr_data,
    output logic                    req_rdy,
    output logic                    ack_vld,
    output logic [DATA_WIDTH-1:0]   rd_data,
    input  logic                    ack_rdy,
    // external port side
    output logic [M-1:0]            ext_req_vld,
    output logic                    ext_rd_en,
    output logic                    ext_wr_en,
    output logic [ADDR_WIDTH-1:0]   ext_addr,
    output logic [DATA_WIDTH-1:0]   ext_wr_data,
    input  logic [M-1:0]            ext_req_rdy,
    input  logic [M-1:0]            ext_ack_vld,
    input  logic [M*DATA_WIDTH-1:0] ext_rd_data
);

    logic [N-1:0]          reg_sel, reg_sel_ff;
    logic [M-1:0]          ext_sel, ext_sel_ff, tgt_rdy_ext;
    logic                  dummy_reg, soft_rst, dummy_reg_ff, soft_rst_ff;
    logic [ADDR_WIDTH-1:0] addr_ff;
    logic                  wr_en_ff, rd_en_ff, acc_done, global_sync_reset;
    logic [DATA_WIDTH-1:0] wr_data_ff, rd_data_in, rd_data_int, rd_data_ext;
    logic                  ack_vld_in, ack_vld_in_int, ack_vld_in_ext;

    // only the addressed side drives its response non-zero
    assign ack_vld_in = ack_vld_in_int | ack_vld_in_ext;
    assign rd_data_in = rd_data_int | rd_data_ext;

    reg_addr_decode #(.ADDR_WIDTH(ADDR_WIDTH), .N(N), .M(M)) u_decode (
        .addr(addr), .reg_sel(reg_sel), .ext_sel(ext_sel),
        .dummy_reg(dummy_reg), .soft_rst(soft_rst)
    );

    reg_slv_fsm #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .N(N), .M(M)) u_fsm (
        .clk(clk), .rstn(rstn), .req_vld(req_vld), .rd_en(rd_en), .wr_en(wr_en),
        .addr(addr), .wr_data(wr_data), .req_rdy(req_rdy),
        .reg_sel(reg_sel), .ext_sel(ext_sel), .dummy_reg(dummy_reg), .soft_rst(soft_rst),
        .addr_ff(addr_ff), .wr_en_ff(wr_en_ff), .rd_en_ff(rd_en_ff), .wr_data_ff(wr_data_ff),
        .reg_sel_ff(reg_sel_ff), .ext_sel_ff(ext_sel_ff), .dummy_reg_ff(dummy_reg_ff),
        .soft_rst_ff(soft_rst_ff), .tgt_rdy({tgt_rdy_ext, 1'b1}), .ack_vld_in(ack_vld_in),
        .rd_data_in(rd_data_in), .global_sync_reset(global_sync_reset),
        .ack_vld(ack_vld), .rd_data(rd_data), .ack_rdy(ack_rdy), .acc_done(acc_done)
    );

    reg_file #(.DATA_WIDTH(DATA_WIDTH), .N(N)) u_reg_file (
        .clk(clk), .rstn(rstn), .wr_en_ff(wr_en_ff), .rd_en_ff(rd_en_ff),
        .wr_data_ff(wr_data_ff), .reg_sel_ff(reg_sel_ff), .dummy_reg_ff(dummy_reg_ff),
        .soft_rst_ff(soft_rst_ff), .acc_done(acc_done), .ack_vld_in_int(ack_vld_in_int),
        .rd_data_int(rd_data_int), .global_sync_reset(global_sync_reset)
    );

    ext_port_route #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .M(M)) u_ext_route (
        .clk(clk), .rstn(rstn), .addr_ff(addr_ff), .rd_en_ff(rd_en_ff),
        .wr_en_ff(wr_en_ff), .wr_data_ff(wr_data_ff), .ext_sel_ff(ext_sel_ff),
        .fsm_busy(~req_rdy), .ext_req_vld(ext_req_vld), .ext_rd_en(ext_rd_en),
        .ext_wr_en(ext_wr_en), .ext_addr(ext_addr), .ext_wr_data(ext_wr_data),
        .ext_req_rdy(ext_req_rdy), .ext_ack_vld(ext_ack_vld), .ext_rd_data(ext_rd_data),
        .tgt_rdy_ext(tgt_rdy_ext), .ack_vld_in_ext(ack_vld_in_ext), .rd_data_ext(rd_data_ext)
    );

endmodule

/* ext_port_route.sv */
`timescale 1ns/100ps

module ext_port_route #(
    parameter int ADDR_WIDTH = bus_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = bus_pkg::DATA_WIDTH,
    parameter int M          = reg_map_pkg::EXT_NUM
) (
    input  logic                    clk,
    input  logic                    rstn,
    // held request
    input  logic [ADDR_WIDTH-1:0]   addr_ff,
    input  logic                    rd_en_ff,
    input  logic                    wr_en_ff,
    input  logic [DATA_WIDTH-1:0]   wr_data_ff,
    input  logic [M-1:0]            ext_sel_ff,
    input  logic                    fsm_busy,
    // external ports
    output logic [M-1:0]            ext_req_vld,
    output logic                    ext_rd_en,
    output logic                    ext_wr_en,
    output logic [ADDR_WIDTH-1:0]   ext_addr,
    output logic [DATA_WIDTH-1:0]   ext_wr_data,
    input  logic [M-1:0]            ext_req_rdy,
    input  logic [M-1:0]            ext_ack_vld,
    input  logic [M*DATA_WIDTH-1:0] ext_rd_data,
    // back to the fsm
    output logic [M-1:0]            tgt_rdy_ext,
    output logic                    ack_vld_in_ext,
    output logic [DATA_WIDTH-1:0]   rd_data_ext
);

    logic                  taken;
    logic                  ack_hit;
    logic [DATA_WIDTH-1:0] rd_mux;

    // request stays up until the selected port takes it
    assign ext_req_vld = (fsm_busy && !taken) ? ext_sel_ff : '0;
    assign ext_rd_en   = rd_en_ff & |ext_req_vld;
    assign ext_wr_en   = wr_en_ff & |ext_req_vld;
    assign ext_addr    = addr_ff;
    assign ext_wr_data = wr_data_ff;
    assign tgt_rdy_ext = ext_req_rdy & ext_req_vld;

    // cleared only once the fsm is ready again
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            taken <= 1'b0;
        end else if (!fsm_busy) begin
            taken <= 1'b0;
        end else if (|tgt_rdy_ext) begin
            taken <= 1'b1;
        end
    end

    always_comb begin
        ack_hit = 1'b0;
        rd_mux  = '0;
        for (int k = 0; k < M; k++) begin
            if (ext_sel_ff[k]) begin
                ack_hit = ext_ack_vld[k];
                rd_mux  = ext_rd_data[k*DATA_WIDTH +: DATA_WIDTH];
            end
        end
    end

    // registered single-cycle response, zero otherwise
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ack_vld_in_ext <= 1'b0;
            rd_data_ext    <= '0;
        end else begin
            ack_vld_in_ext <= fsm_busy & ack_hit;
            rd_data_ext    <= (fsm_busy && ack_hit) ? rd_mux : '0;
        end
    end

endmodule

/* reg_file.sv */
`timescale 1ns/100ps

module reg_file #(
    parameter int DATA_WIDTH = bus_pkg::DATA_WIDTH,
    parameter int N          = reg_map_pkg::REG_NUM
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  wr_en_ff,
    input  logic                  rd_en_ff,
    input  logic [DATA_WIDTH-1:0] wr_data_ff,
    input  logic [N-1:0]          reg_sel_ff,
    input  logic                  dummy_reg_ff,
    input  logic                  soft_rst_ff,
    input  logic                  acc_done,
    output logic                  ack_vld_in_int,
    output logic [DATA_WIDTH-1:0] rd_data_int,
    output logic                  global_sync_reset
);

    localparam logic [DATA_WIDTH-1:0] RST_VAL   = DATA_WIDTH'(reg_map_pkg::REG_RESET);
    localparam logic [DATA_WIDTH-1:0] DUMMY_VAL = DATA_WIDTH'(bus_pkg::DUMMY_DATA);

    logic [N-1:0][DATA_WIDTH-1:0] regs;
    logic [DATA_WIDTH-1:0]        sel_data;
    logic                         int_hit;

    // everything that is not an external port is answered here
    assign int_hit        = |reg_sel_ff | dummy_reg_ff | soft_rst_ff;
    assign ack_vld_in_int = int_hit;

    always_comb begin
        sel_data = '0;
        for (int i = 0; i < N; i++) begin
            if (reg_sel_ff[i]) begin
                sel_data = regs[i];
            end
        end
    end

    // zero unless reading, the response is ORed with the external side
    always_comb begin
        if (!rd_en_ff || !int_hit) begin
            rd_data_int = '0;
        end else if (dummy_reg_ff || soft_rst_ff) begin
            rd_data_int = DUMMY_VAL;
        end else begin
            rd_data_int = sel_data;
        end
    end

    // one cycle pulse right after the soft reset write is acknowledged
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            global_sync_reset <= 1'b0;
        end else begin
            global_sync_reset <= acc_done & wr_en_ff & soft_rst_ff;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            regs <= {N{RST_VAL}};
        end else if (global_sync_reset) begin
            regs <= {N{RST_VAL}};
        end else if (acc_done && wr_en_ff) begin
            for (int i = 0; i < N; i++) begin
                if (reg_sel_ff[i]) begin
                    regs[i] <= wr_data_ff;
                end
            end
        end
    end

endmodule

/* reg_slv_fsm.sv */
`timescale 1ns/100ps

module reg_slv_fsm #(
    parameter int ADDR_WIDTH = bus_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = bus_pkg::DATA_WIDTH,
    parameter int N          = reg_map_pkg::REG_NUM,
    parameter int M          = reg_map_pkg::EXT_NUM
) (
    input  logic                  clk,
    input  logic                  rstn,
    // bus request
    input  logic                  req_vld,
    input  logic                  rd_en,
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] wr_data,
    output logic                  req_rdy,
    // decode of the live address
    input  logic [N-1:0]          reg_sel,
    input  logic [M-1:0]          ext_sel,
    input  logic                  dummy_reg,
    input  logic                  soft_rst,
    // held request for the access stage
    output logic [ADDR_WIDTH-1:0] addr_ff,
    output logic                  wr_en_ff,
    output logic                  rd_en_ff,
    output logic [DATA_WIDTH-1:0] wr_data_ff,
    output logic [N-1:0]          reg_sel_ff,
    output logic [M-1:0]          ext_sel_ff,
    output logic                  dummy_reg_ff,
    output logic                  soft_rst_ff,
    // access stage response
    input  logic [M:0]            tgt_rdy,
    input  logic                  ack_vld_in,
    input  logic [DATA_WIDTH-1:0] rd_data_in,
    input  logic                  global_sync_reset,
    // bus response
    output logic                  ack_vld,
    output logic [DATA_WIDTH-1:0] rd_data,
    input  logic                  ack_rdy,
    output logic                  acc_done
);

    bus_pkg::slv_state_t state;
    bus_pkg::slv_state_t next_state;
    logic                tgt_ok;

    // bit 0 stands for the internal side, taken when no port is selected
    assign tgt_ok   = |(tgt_rdy & {ext_sel_ff, ~|ext_sel_ff});
    assign acc_done = ack_vld & ack_rdy;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= bus_pkg::st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            bus_pkg::st_idle: begin
                if (req_vld && req_rdy) begin
                    next_state = bus_pkg::st_wait;
                end
            end
            bus_pkg::st_wait: begin
                if (tgt_ok) begin
                    next_state = bus_pkg::st_ack;
                end
            end
            bus_pkg::st_ack: begin
                if (acc_done) begin
                    next_state = bus_pkg::st_idle;
                end
            end
            default: next_state = bus_pkg::st_idle;
        endcase
        // soft reset drops whatever is still pending
        if (global_sync_reset) begin
            next_state = bus_pkg::st_idle;
        end
    end

    // ready only for a full idle cycle, so it comes back one cycle after an ack
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_rdy <= 1'b0;
        end else begin
            req_rdy <= (state == bus_pkg::st_idle) && (next_state == bus_pkg::st_idle);
        end
    end

    // request capture, follows the bus while idle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_en_ff     <= 1'b0;
            rd_en_ff     <= 1'b0;
            reg_sel_ff   <= '0;
            ext_sel_ff   <= '0;
            dummy_reg_ff <= 1'b0;
            soft_rst_ff  <= 1'b0;
        end else if (state == bus_pkg::st_idle) begin
            wr_en_ff     <= wr_en;
            rd_en_ff     <= rd_en;
            reg_sel_ff   <= reg_sel;
            ext_sel_ff   <= ext_sel;
            dummy_reg_ff <= dummy_reg;
            soft_rst_ff  <= soft_rst;
        end
    end

    always_ff @(posedge clk) begin
        if (state == bus_pkg::st_idle) begin
            addr_ff    <= addr;
            wr_data_ff <= wr_data;
        end
    end

    // response register
    // set once in ack, then frozen until the handshake
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ack_vld <= 1'b0;
        end else if (next_state != bus_pkg::st_ack) begin
            ack_vld <= 1'b0;
        end else if (state == bus_pkg::st_ack && ack_vld_in) begin
            ack_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (next_state == bus_pkg::st_ack && state == bus_pkg::st_ack &&
            ack_vld_in && !ack_vld) begin
            rd_data <= rd_data_in;
        end
    end

endmodule

/* reg_addr_decode.sv */
`timescale 1ns/100ps

module reg_addr_decode #(
    parameter int ADDR_WIDTH = bus_pkg::ADDR_WIDTH,
    parameter int N          = reg_map_pkg::REG_NUM,
    parameter int M          = reg_map_pkg::EXT_NUM
) (
    input  logic [ADDR_WIDTH-1:0] addr,
    output logic [N-1:0]          reg_sel,
    output logic [M-1:0]          ext_sel,
    output logic                  dummy_reg,
    output logic                  soft_rst
);

    localparam logic [ADDR_WIDTH-1:0] SOFT_ADDR = ADDR_WIDTH'(reg_map_pkg::SOFT_RST_ADDR);

    always_comb begin
        reg_sel   = '0;
        ext_sel   = '0;
        soft_rst  = 1'b0;
        dummy_reg = 1'b0;

        // soft reset wins over a register slot that might overlap it
        if (addr == SOFT_ADDR) begin
            soft_rst = 1'b1;
        end else begin
            // exact word match only, misaligned hits fall to dummy
            for (int i = 0; i < N; i++) begin
                if (addr == ADDR_WIDTH'(reg_map_pkg::REG_BASE + i * reg_map_pkg::REG_STEP)) begin
                    reg_sel[i] = 1'b1;
                end
            end

            // inclusive upper bound keeps the last window from wrapping
            for (int k = 0; k < M; k++) begin
                if (addr >= ADDR_WIDTH'(reg_map_pkg::EXT_BASE + k * reg_map_pkg::EXT_SPAN) &&
                    addr <= ADDR_WIDTH'(reg_map_pkg::EXT_BASE +
                                        (k + 1) * reg_map_pkg::EXT_SPAN - 1)) begin
                    ext_sel[k] = 1'b1;
                end
            end

            dummy_reg = ~|{reg_sel, ext_sel};
        end
    end

endmodule

/* reg_map_pkg.sv */
package reg_map_pkg;

    // default sizes of the internal and external parts
    parameter int REG_NUM = 8;
    parameter int EXT_NUM = 2;

    // internal registers, one word per 4-byte step
    parameter logic [31:0] REG_BASE = 32'h0000_0000;
    parameter int unsigned REG_STEP = 4;

    // value after power-on reset or soft reset
    parameter logic [31:0] REG_RESET = 32'h0000_0000;

    // write-only, a write here clears the register file
    parameter logic [31:0] SOFT_RST_ADDR = 32'h0000_00fc;

    // external windows
    // port k owns EXT_BASE + k*EXT_SPAN up to the next window
    parameter logic [31:0] EXT_BASE = 32'h0000_1000;
    parameter logic [31:0] EXT_SPAN = 32'h0000_0100;

endpackage

/* bus_pkg.sv */
package bus_pkg;

    // default bus widths, the top level may override them
    parameter int ADDR_WIDTH = 16;
    parameter int DATA_WIDTH = 32;

    // slave fsm states
    // encoding 2'b11 is never used
    typedef enum logic [1:0] {
        st_idle = 2'b00,
        st_wait = 2'b01,
        st_ack  = 2'b10
    } slv_state_t;

    // returned on reads of unmapped or write-only addresses
    parameter logic [31:0] DUMMY_DATA = 32'hdead_beef;

endpackage
